/* all.f */
design/throttle_pkg.sv
design/throttle_ctrl_if.sv
design/throttle_sequencer.sv
design/failsafe_timer.sv
design/throttle_conditioner.sv
design/throttle_curve.sv
design/throttle_slew_limiter.sv
design/throttle_top.sv
bench/throttle_sva.sv
bench/tb_throttle.sv

/* bench/tb_throttle.sv */
/*
 * Throttle path testbench
 * Directed and random samples checked against a reference model of the rules
 */
module tb_throttle;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FAILSAFE_CYCLES = 200;
    localparam int WAIT_LIMIT = 4 * FAILSAFE_CYCLES;

    logic us_clk;
    logic resetn;
    logic imu_good;
    logic flight_mode;
    logic limiter_bypass;
    logic [7:0] sample_value;
    logic sample_valid;
    logic sample_ready;
    logic [7:0] throttle_out;
    logic throttle_valid;
    logic active;
    logic link_lost;

    int errors = 0;
    int accepts = 0;
    int valids = 0;
    int expected_q[$];
    logic [31:0] rng = 32'h1b56_dcf3;

    // Reference model history
    int ref_prev_latched = 0;
    int ref_prev_out = 0;

    // Waiting edges without a sample since the last pass started
    int silent = 0;

    // Handshake as seen at the last falling edge
    logic was_ready = 1'b0;
    logic was_valid = 1'b0;
    logic [7:0] was_value = 8'd0;

    throttle_top #(.FAILSAFE_CYCLES(FAILSAFE_CYCLES)) dut_i (.*);

    initial begin
        us_clk = 1'b0;
        forever #20 us_clk = ~us_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Clamp, deglitch, curve, slew and commit of one pass
    function automatic int predict_out(input int raw, input logic fs, input logic acro,
                                       input logic byp);
        int lat;
        int deb;
        int s;
        int lim;
        lat = (fs || raw < 10) ? 0 : ((raw > 250) ? 250 : raw);
        deb = (lat <= 10 && ref_prev_latched > 10) ? ref_prev_latched : lat;
        ref_prev_latched = lat;
        if (acro) begin
            s = (deb < 42) ? 2 * deb : ((deb > 209) ? 2 * deb - 252 : deb / 2 + 61);
        end else begin
            s = (deb < 35) ? 4 * deb : deb / 4 + 128;
        end
        if (s < 10) begin
            lim = 0;
        end else if (s > ref_prev_out + 5) begin
            lim = (ref_prev_out + 5 > 250) ? 250 : ref_prev_out + 5;
        end else if (ref_prev_out > s + 5) begin
            lim = (ref_prev_out - 5 < 10) ? 0 : ref_prev_out - 5;
        end else begin
            lim = (s > 250) ? 250 : s;
        end
        ref_prev_out = byp ? lat : lim;
        return ref_prev_out;
    endfunction

    task automatic finish_run(input string timed_out_on);
        if (timed_out_on != "") begin
            errors++;
            $display("Timeout while waiting for %s", timed_out_on);
        end
        $display("Errors: %0d, accepts: %0d, valid pulses: %0d", errors, accepts, valids);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Offer a sample until accepted, then wait for its output unless the next one follows
    task automatic send_sample(input logic [7:0] value, input logic acro, input logic byp,
                               input logic back_to_back);
        int cycles;
        cycles = 0;
        flight_mode <= acro;
        limiter_bypass <= byp;
        sample_value <= value;
        sample_valid <= 1'b1;
        do begin
            @(negedge us_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                finish_run("sample_ready");
            end
        end while (!sample_ready);
        @(posedge us_clk);
        if (!back_to_back) begin
            sample_valid <= 1'b0;
            cycles = 0;
            do begin
                @(negedge us_clk);
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    finish_run("throttle_valid");
                end
            end while (!throttle_valid);
            @(posedge us_clk);
        end
    endtask

    // Expected values queue up at each accept and at each predicted failsafe pass
    always @(negedge us_clk) begin
        int expected;
        logic started;
        started = 1'b0;
        if (resetn) begin
            if (was_ready && was_valid) begin
                expected_q.push_back(predict_out(int'(was_value), 1'b0, flight_mode,
                                                 limiter_bypass));
                accepts++;
                silent = 0;
                started = 1'b1;
            end else if (was_ready) begin
                // Silent for a full period, this waiting edge starts a failsafe pass
                silent++;
                if (silent > FAILSAFE_CYCLES) begin
                    expected_q.push_back(predict_out(0, 1'b1, flight_mode, limiter_bypass));
                    accepts++;
                    silent = 0;
                    started = 1'b1;
                end
            end
            if (was_ready) begin
                assert (active == started) else begin
                    errors++;
                    $display("Error: %0t active got %0b expected %0b", $time, active, started);
                end
            end
            if (throttle_valid) begin
                valids++;
                assert (expected_q.size() > 0) else begin
                    errors++;
                    $display("Output valid pulse at %0t with no sample in flight", $time);
                end
                if (expected_q.size() > 0) begin
                    expected = expected_q.pop_front();
                    assert (int'(throttle_out) == expected) else begin
                        errors++;
                        $display("Error: %0t throttle_out got %0d expected %0d",
                                 $time, throttle_out, expected);
                    end
                end
            end
        end
        was_ready = sample_ready;
        was_valid = sample_valid;
        was_value = sample_value;
    end

    initial begin
        int cycles;
        resetn = 1'b0;
        imu_good = 1'b0;
        flight_mode = 1'b0;
        limiter_bypass = 1'b0;
        sample_value = 8'd0;
        sample_valid = 1'b0;
        repeat (3) @(posedge us_clk);
        resetn <= 1'b1;
        sample_value <= 8'd200;
        sample_valid <= 1'b1;

        // A sample is offered but nothing moves while the IMU is not ready
        repeat (8) begin
            @(negedge us_clk);
            assert (!sample_ready && throttle_out == 8'd0) else begin
                errors++;
                $display("Error: %0t sample_ready got %0b, throttle_out got %0d, expected 0, 0",
                         $time, sample_ready, throttle_out);
            end
        end
        @(posedge us_clk);
        sample_valid <= 1'b0;
        @(posedge us_clk);
        imu_good <= 1'b1;

        // Random samples through both curves
        repeat (40) begin
            rng = xorshift32(rng);
            send_sample(rng[7:0], rng[8], 1'b0, 1'b0);
        end

        // Full step from idle climbs at the slew limit
        repeat (2) send_sample(8'd0, 1'b1, 1'b0, 1'b0);
        repeat (50) send_sample(8'd250, 1'b1, 1'b0, 1'b0);

        // Lone idle held off, a second idle in a row cuts the throttle
        send_sample(8'd0, 1'b1, 1'b0, 1'b0);
        send_sample(8'd250, 1'b1, 1'b0, 1'b0);
        repeat (2) send_sample(8'd0, 1'b1, 1'b0, 1'b0);

        // Bypass gives the clamped sample
        send_sample(8'd255, 1'b0, 1'b1, 1'b0);
        send_sample(8'd4, 1'b1, 1'b1, 1'b0);
        repeat (20) begin
            rng = xorshift32(rng);
            send_sample(rng[7:0], rng[8], 1'b1, 1'b0);
        end

        // Receiver goes silent after a high throttle
        repeat (6) send_sample(8'd180, 1'b0, 1'b0, 1'b0);
        cycles = 0;
        while (!(link_lost && throttle_out == 8'd0)) begin
            @(negedge us_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                finish_run("failsafe passes to reach idle");
            end
        end
        @(posedge us_clk);
        send_sample(8'd120, 1'b0, 1'b0, 1'b0);
        @(negedge us_clk);
        assert (!link_lost) else begin
            errors++;
            $display("Error: %0t link_lost got %0b expected 0", $time, link_lost);
        end
        @(posedge us_clk);

        // Valid held through busy passes
        repeat (12) begin
            rng = xorshift32(rng);
            send_sample(rng[7:0], 1'b0, 1'b0, 1'b1);
        end
        send_sample(8'd60, 1'b0, 1'b0, 1'b0);
        @(negedge us_clk);
        assert (accepts == valids && expected_q.size() == 0) else begin
            errors++;
            $display("Accepted %0d samples but counted %0d output valid pulses", accepts, valids);
        end
        finish_run("");
    end

endmodule

/* bench/throttle_sva.sv */
/*
 * Handshake and timing assertions for the throttle path
 */
module throttle_sva (
    input logic us_clk,
    input logic resetn,
    input logic sample_valid,
    input logic sample_ready,
    input logic throttle_valid,
    input logic active
);
    timeunit 1ns;
    timeprecision 100ps;

    // Valid rises on the fourth edge after the accepting edge
    assert property (@(posedge us_clk) disable iff (!resetn)
        (sample_valid && sample_ready) |-> ##4 !throttle_valid ##1 throttle_valid)
        else $error("throttle_valid not four edges after the accept");

    assert property (@(posedge us_clk) disable iff (!resetn)
        throttle_valid |=> !throttle_valid)
        else $error("throttle_valid longer than one cycle");

    // Busy from the accept up to the commit edge, then ready again
    assert property (@(posedge us_clk) disable iff (!resetn)
        (sample_valid && sample_ready) |=>
            (active && !sample_ready) ##1 (active && !sample_ready) ##1
            (active && !sample_ready) ##1 (active && !sample_ready) ##1
            (sample_ready && !active))
        else $error("active or sample_ready wrong during a pass");

endmodule

bind throttle_top throttle_sva sva_i (
    .us_clk         (us_clk),
    .resetn         (resetn),
    .sample_valid   (sample_valid),
    .sample_ready   (sample_ready),
    .throttle_valid (throttle_valid),
    .active         (active)
);

/* design/failsafe_timer.sv */
/*
 * Receiver silence timer
 * Counts armed cycles and pulses expired after FAILSAFE_CYCLES
 */
module failsafe_timer #(
    parameter int FAILSAFE_CYCLES = 2000
) (
    input  logic us_clk,
    input  logic resetn,
    input  logic armed,
    input  logic restart,
    output logic expired
);

    localparam int CNT_W = $clog2(FAILSAFE_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(FAILSAFE_CYCLES - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
            expired <= 1'b0;
        end else if (restart) begin
            count <= '0;
            expired <= 1'b0;
        end else if (armed) begin
            // Wrap at the limit so the next period starts clean
            if (count == LAST_COUNT) begin
                count <= '0;
                expired <= 1'b1;
            end else begin
                count <= count + 1'b1;
                expired <= 1'b0;
            end
        end else begin
            expired <= 1'b0;
        end
    end

endmodule

/* design/throttle_conditioner.sv */
/*
 * Throttle input conditioner
 * Latches the sample with clamping, then drops a lone idle reading
 */
module throttle_conditioner (
    input  logic                    us_clk,
    input  logic                    resetn,
    input  throttle_pkg::throttle_t sample_value,
    throttle_ctrl_if.stage          ctrl,
    output throttle_pkg::throttle_t latched,
    output throttle_pkg::throttle_t debounced
);

    throttle_pkg::throttle_t prev_latched;
    throttle_pkg::throttle_t clamped;
    logic lone_idle;

    // Failsafe passes behave as a zero sample
    always_comb begin
        if (ctrl.failsafe_sel || (sample_value < throttle_pkg::IDLE_FLOOR)) begin
            clamped = '0;
        end else if (sample_value > throttle_pkg::THROTTLE_CEILING) begin
            clamped = throttle_pkg::THROTTLE_CEILING;
        end else begin
            clamped = sample_value;
        end
    end

    // Idle now but not before, likely a receiver glitch
    assign lone_idle = (latched <= throttle_pkg::IDLE_FLOOR) &&
                       (prev_latched > throttle_pkg::IDLE_FLOOR);

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            latched <= '0;
        end else if (ctrl.latch_en) begin
            latched <= clamped;
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            debounced <= '0;
            prev_latched <= '0;
        end else if (ctrl.deglitch_en) begin
            debounced <= lone_idle ? prev_latched : latched;
            // A second idle in a row passes through
            prev_latched <= latched;
        end
    end

endmodule

/* design/throttle_ctrl_if.sv */
/*
 * Step enables from the throttle sequencer to the datapath stages
 */
interface throttle_ctrl_if;

    // Pulse on the accepting edge
    logic latch_en;
    // Latch an idle sample instead of the receiver value
    logic failsafe_sel;

    // One-hot step enables, one per sequencer state
    logic deglitch_en;
    logic scale_en;
    logic limit_en;
    logic commit_en;

    modport seq (
        output latch_en,
        output failsafe_sel,
        output deglitch_en,
        output scale_en,
        output limit_en,
        output commit_en
    );

    modport stage (
        input latch_en,
        input failsafe_sel,
        input deglitch_en,
        input scale_en,
        input limit_en,
        input commit_en
    );

endinterface

/* design/throttle_curve.sv */
/*
 * Flight-mode throttle curve
 * Piecewise-linear mapping, acro or easy response
 */
module throttle_curve (
    input  logic                    us_clk,
    input  logic                    resetn,
    input  logic                    flight_mode,
    input  throttle_pkg::throttle_t debounced,
    throttle_ctrl_if.stage          ctrl,
    output throttle_pkg::ops_t      scaled
);

    throttle_pkg::ops_t value;
    throttle_pkg::ops_t curve;

    assign value = throttle_pkg::ops_t'(debounced);

    always_comb begin
        if (flight_mode) begin
            // Acro: fast at both ends, flat around hover
            if (debounced < throttle_pkg::ACRO_LOW_KNEE) begin
                curve = value << 1;
            end else if (debounced > throttle_pkg::ACRO_HIGH_KNEE) begin
                curve = (value << 1) - throttle_pkg::ACRO_HIGH_OFFSET;
            end else begin
                curve = (value >> 1) + throttle_pkg::ACRO_MID_OFFSET;
            end
        end else begin
            // Easy: quick spin-up, then a gentle slope with no top knee
            if (debounced < throttle_pkg::EASY_KNEE) begin
                curve = value << 2;
            end else begin
                curve = (value >> 2) + throttle_pkg::EASY_OFFSET;
            end
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            scaled <= '0;
        end else if (ctrl.scale_en) begin
            scaled <= curve;
        end
    end

endmodule

/* design/throttle_pkg.sv */
/*
 * Throttle path shared definitions
 * Value widths, sequencer states and the curve and slew constants
 */
package throttle_pkg;

    // Receiver and motor throttle value
    typedef logic [7:0] throttle_t;

    // Working width, wide enough for 4x curve results
    typedef logic [9:0] ops_t;

    // Sequencer steps, one sample in flight
    typedef enum logic [2:0] {
        WAIT_IMU = 3'd0,
        WAITING  = 3'd1,
        DEGLITCH = 3'd2,
        SCALE    = 3'd3,
        LIMIT    = 3'd4,
        COMMIT   = 3'd5
    } seq_state_t;

    // At or below this the motors are considered idle
    localparam throttle_t IDLE_FLOOR = 8'd10;

    // Highest throttle ever passed to the motor stage
    localparam throttle_t THROTTLE_CEILING = 8'd250;

    // Largest output step per update
    localparam throttle_t CHANGE_LIMIT = 8'd5;

    // Acro curve, steep below the low knee and above the high knee
    localparam throttle_t ACRO_LOW_KNEE = 8'd42;
    localparam throttle_t ACRO_HIGH_KNEE = 8'd209;
    localparam ops_t ACRO_HIGH_OFFSET = 10'd252;
    localparam ops_t ACRO_MID_OFFSET = 10'd61;

    // Easy curve, steep start then a gentle slope to the top
    localparam throttle_t EASY_KNEE = 8'd35;
    localparam ops_t EASY_OFFSET = 10'd128;

endpackage

/* design/throttle_sequencer.sv */
/*
 * Throttle sequencer
 * Waits for the IMU, accepts samples or failsafe passes and steps
 * the datapath through deglitch, scale, limit and commit
 */
module throttle_sequencer (
    input  logic us_clk,
    input  logic resetn,
    input  logic imu_good,
    input  logic sample_valid,
    output logic sample_ready,
    output logic active,
    output logic link_lost,
    input  logic expired,
    output logic restart,
    output logic armed,
    throttle_ctrl_if.seq ctrl
);

    throttle_pkg::seq_state_t state;
    throttle_pkg::seq_state_t next_state;

    logic accept;
    logic failsafe_start;

    assign sample_ready = (state == throttle_pkg::WAITING);

    // A real sample wins over a failsafe expiry in the same cycle
    assign accept = sample_ready && sample_valid;
    assign failsafe_start = sample_ready && expired && !sample_valid;

    assign ctrl.latch_en = accept || failsafe_start;
    assign ctrl.failsafe_sel = failsafe_start;
    assign ctrl.deglitch_en = (state == throttle_pkg::DEGLITCH);
    assign ctrl.scale_en = (state == throttle_pkg::SCALE);
    assign ctrl.limit_en = (state == throttle_pkg::LIMIT);
    assign ctrl.commit_en = (state == throttle_pkg::COMMIT);

    // Busy from the accepting edge up to the commit edge
    assign active = (state != throttle_pkg::WAIT_IMU) && (state != throttle_pkg::WAITING);

    // Timer only runs while waiting, any pass starts a fresh period
    assign armed = sample_ready;
    assign restart = ctrl.latch_en;

    always_comb begin
        next_state = state;
        case (state)
            throttle_pkg::WAIT_IMU: begin
                if (imu_good) begin
                    next_state = throttle_pkg::WAITING;
                end
            end
            throttle_pkg::WAITING: begin
                if (ctrl.latch_en) begin
                    next_state = throttle_pkg::DEGLITCH;
                end
            end
            throttle_pkg::DEGLITCH: next_state = throttle_pkg::SCALE;
            throttle_pkg::SCALE:    next_state = throttle_pkg::LIMIT;
            throttle_pkg::LIMIT:    next_state = throttle_pkg::COMMIT;
            throttle_pkg::COMMIT:   next_state = throttle_pkg::WAITING;
            default:                next_state = throttle_pkg::WAIT_IMU;
        endcase
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            state <= throttle_pkg::WAIT_IMU;
        end else begin
            state <= next_state;
        end
    end

    // Link is lost on a failsafe pass and recovered by a real sample
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            link_lost <= 1'b0;
        end else if (failsafe_start) begin
            link_lost <= 1'b1;
        end else if (accept) begin
            link_lost <= 1'b0;
        end
    end

endmodule

/* design/throttle_slew_limiter.sv */
/*
 * Throttle slew limiter and output stage
 * Bounds the change per update, then commits the output with a valid pulse
 */
module throttle_slew_limiter (
    input  logic                    us_clk,
    input  logic                    resetn,
    input  logic                    limiter_bypass,
    input  throttle_pkg::throttle_t latched,
    input  throttle_pkg::ops_t      scaled,
    throttle_ctrl_if.stage          ctrl,
    output throttle_pkg::throttle_t throttle_out,
    output logic                    throttle_valid
);

    throttle_pkg::throttle_t prev_out;
    throttle_pkg::throttle_t limited;
    throttle_pkg::throttle_t limit_next;
    throttle_pkg::throttle_t commit_value;

    throttle_pkg::ops_t prev_wide;
    throttle_pkg::ops_t step_up;
    throttle_pkg::ops_t step_down;
    throttle_pkg::ops_t scaled_plus;

    assign prev_wide = throttle_pkg::ops_t'(prev_out);
    assign step_up = prev_wide + throttle_pkg::ops_t'(throttle_pkg::CHANGE_LIMIT);
    assign step_down = prev_wide - throttle_pkg::ops_t'(throttle_pkg::CHANGE_LIMIT);
    assign scaled_plus = scaled + throttle_pkg::ops_t'(throttle_pkg::CHANGE_LIMIT);

    always_comb begin
        if (scaled < throttle_pkg::ops_t'(throttle_pkg::IDLE_FLOOR)) begin
            limit_next = '0;
        end else if (scaled > step_up) begin
            // Rising too fast
            if (step_up > throttle_pkg::ops_t'(throttle_pkg::THROTTLE_CEILING)) begin
                limit_next = throttle_pkg::THROTTLE_CEILING;
            end else begin
                limit_next = throttle_pkg::throttle_t'(step_up);
            end
        end else if (prev_wide > scaled_plus) begin
            // Falling too fast, cut the motor once near idle
            if (step_down < throttle_pkg::ops_t'(throttle_pkg::IDLE_FLOOR)) begin
                limit_next = '0;
            end else begin
                limit_next = throttle_pkg::throttle_t'(step_down);
            end
        end else if (scaled > throttle_pkg::ops_t'(throttle_pkg::THROTTLE_CEILING)) begin
            limit_next = throttle_pkg::THROTTLE_CEILING;
        end else begin
            limit_next = throttle_pkg::throttle_t'(scaled);
        end
    end

    assign commit_value = limiter_bypass ? latched : limited;

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            limited <= '0;
        end else if (ctrl.limit_en) begin
            limited <= limit_next;
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            throttle_out <= '0;
            prev_out <= '0;
            throttle_valid <= 1'b0;
        end else begin
            throttle_valid <= ctrl.commit_en;
            if (ctrl.commit_en) begin
                throttle_out <= commit_value;
                prev_out <= commit_value;
            end
        end
    end

endmodule

/* design/throttle_top.sv */
/*
 * Throttle path top level
 * Sequencer, failsafe timer and the three datapath stages
 */
module throttle_top #(
    parameter int FAILSAFE_CYCLES = 2000
) (
    input  logic                    us_clk,
    input  logic                    resetn,
    input  logic                    imu_good,
    input  logic                    flight_mode,
    input  logic                    limiter_bypass,
    input  throttle_pkg::throttle_t sample_value,
    input  logic                    sample_valid,
    output logic                    sample_ready,
    output throttle_pkg::throttle_t throttle_out,
    output logic                    throttle_valid,
    output logic                    active,
    output logic                    link_lost
);

    throttle_pkg::throttle_t latched;
    throttle_pkg::throttle_t debounced;
    throttle_pkg::ops_t scaled;

    logic restart;
    logic armed;
    logic expired;

    throttle_ctrl_if ctrl ();

    throttle_sequencer u_sequencer (
        .us_clk       (us_clk),
        .resetn       (resetn),
        .imu_good     (imu_good),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .active       (active),
        .link_lost    (link_lost),
        .expired      (expired),
        .restart      (restart),
        .armed        (armed),
        .ctrl         (ctrl.seq)
    );

    failsafe_timer #(
        .FAILSAFE_CYCLES (FAILSAFE_CYCLES)
    ) u_failsafe_timer (
        .us_clk  (us_clk),
        .resetn  (resetn),
        .armed   (armed),
        .restart (restart),
        .expired (expired)
    );

    throttle_conditioner u_conditioner (
        .us_clk       (us_clk),
        .resetn       (resetn),
        .sample_value (sample_value),
        .ctrl         (ctrl.stage),
        .latched      (latched),
        .debounced    (debounced)
    );

    throttle_curve u_curve (
        .us_clk      (us_clk),
        .resetn      (resetn),
        .flight_mode (flight_mode),
        .debounced   (debounced),
        .ctrl        (ctrl.stage),
        .scaled      (scaled)
    );

    throttle_slew_limiter u_slew_limiter (
        .us_clk         (us_clk),
        .resetn         (resetn),
        .limiter_bypass (limiter_bypass),
        .latched        (latched),
        .scaled         (scaled),
        .ctrl           (ctrl.stage),
        .throttle_out   (throttle_out),
        .throttle_valid (throttle_valid)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the throttle path testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_throttle -f all.f -o sim_throttle
./obj_dir/sim_throttle > sim.log 2>&1
cat sim.log
if grep -q "Test failures found" sim.log; then
    exit 1
fi
